//--- rtl/arm_pkg.sv
`default_nettype none

package arm_pkg;

	// one fetched word in its dp, ls and br views
	typedef union packed {
		struct packed {
			logic [3:0]  cond;
			logic [1:0]  cls;
			logic        imm;
			logic [3:0]  opcode;
			logic        s;
			logic [3:0]  rn;
			logic [3:0]  rd;
			logic [11:0] op2;
		} dp;
		struct packed {
			logic [3:0]  cond;
			logic [1:0]  cls;
			logic        imm;     // register offset form unsupported
			logic        p;
			logic        u;
			logic        b;       // byte transfer treated as word
			logic        w;
			logic        l;
			logic [3:0]  rn;
			logic [3:0]  rd;
			logic [11:0] offset;
		} ls;
		struct packed {
			logic [3:0]  cond;
			logic [1:0]  cls;
			logic        one;     // bit 25 set for B/BL
			logic        link;
			logic [23:0] offset;
		} br;
	} instr_u;

	localparam logic [3:0] OP_AND = 4'h0;
	localparam logic [3:0] OP_EOR = 4'h1;
	localparam logic [3:0] OP_SUB = 4'h2;
	localparam logic [3:0] OP_RSB = 4'h3;
	localparam logic [3:0] OP_ADD = 4'h4;
	localparam logic [3:0] OP_ADC = 4'h5;
	localparam logic [3:0] OP_SBC = 4'h6;
	localparam logic [3:0] OP_RSC = 4'h7;
	localparam logic [3:0] OP_TST = 4'h8;
	localparam logic [3:0] OP_TEQ = 4'h9;
	localparam logic [3:0] OP_CMP = 4'ha;
	localparam logic [3:0] OP_CMN = 4'hb;
	localparam logic [3:0] OP_ORR = 4'hc;
	localparam logic [3:0] OP_MOV = 4'hd;
	localparam logic [3:0] OP_BIC = 4'he;
	localparam logic [3:0] OP_MVN = 4'hf;

	localparam logic [3:0] COND_EQ = 4'h0;
	localparam logic [3:0] COND_NE = 4'h1;
	localparam logic [3:0] COND_CS = 4'h2;
	localparam logic [3:0] COND_CC = 4'h3;
	localparam logic [3:0] COND_MI = 4'h4;
	localparam logic [3:0] COND_PL = 4'h5;
	localparam logic [3:0] COND_VS = 4'h6;
	localparam logic [3:0] COND_VC = 4'h7;
	localparam logic [3:0] COND_HI = 4'h8;
	localparam logic [3:0] COND_LS = 4'h9;
	localparam logic [3:0] COND_GE = 4'ha;
	localparam logic [3:0] COND_LT = 4'hb;
	localparam logic [3:0] COND_GT = 4'hc;
	localparam logic [3:0] COND_LE = 4'hd;
	localparam logic [3:0] COND_AL = 4'he;

	localparam logic [1:0] SH_LSL = 2'b00;
	localparam logic [1:0] SH_LSR = 2'b01;
	localparam logic [1:0] SH_ASR = 2'b10;
	localparam logic [1:0] SH_ROR = 2'b11;

	localparam logic [1:0] ST_INIT = 2'h0;
	localparam logic [1:0] ST_IF   = 2'h1;
	localparam logic [1:0] ST_ID   = 2'h2;
	localparam logic [1:0] ST_EX   = 2'h3;

	localparam logic [1:0] CLASS_DP = 2'b00;
	localparam logic [1:0] CLASS_LS = 2'b01;
	localparam logic [1:0] CLASS_BR = 2'b10;

endpackage

`default_nettype wire

//--- rtl/core_ifs.sv
`timescale 1ns/100ps
`default_nettype none

interface reg_port_if;
	logic [3:0]  ra_addr;
	logic [3:0]  rb_addr;
	logic [31:0] ra_data;   // r15 reads as pc+8
	logic [31:0] rb_data;
	logic        wr_en;
	logic [3:0]  wr_addr;
	logic [31:0] wr_data;
	logic        pc_we;
	logic [31:0] pc_wdata;
	logic [31:0] pc;

	modport ctrl (
		output ra_addr, rb_addr, wr_en, wr_addr, wr_data, pc_we, pc_wdata,
		input  ra_data, rb_data, pc
	);
	modport regs (
		input  ra_addr, rb_addr, wr_en, wr_addr, wr_data, pc_we, pc_wdata,
		output ra_data, rb_data, pc
	);
endinterface

interface alu_if;
	logic [3:0]  opcode;
	logic [31:0] rn_val;
	logic [31:0] rm_val;
	logic [11:0] op2;
	logic        imm;
	logic        carry_in;
	logic        v_in;        // kept as V for logical ops
	logic [31:0] result;
	logic        n;
	logic        z;
	logic        c;
	logic        v;
	logic        writes_rd;

	modport ctrl (
		output opcode, rn_val, rm_val, op2, imm, carry_in, v_in,
		input  result, n, z, c, v, writes_rd
	);
	modport alu (
		input  opcode, rn_val, rm_val, op2, imm, carry_in, v_in,
		output result, n, z, c, v, writes_rd
	);
endinterface

interface shift_if;
	logic [11:0] op2;
	logic        imm;
	logic [31:0] rm_val;
	logic        carry_in;
	logic [31:0] operand;
	logic        carry;

	modport src (output op2, imm, rm_val, carry_in, input operand, carry);
	modport shifter (input op2, imm, rm_val, carry_in, output operand, carry);
endinterface

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
	parameter logic [31:0] RESET_VECTOR = 32'h0800_0000
) (
	input  logic     clk,
	input  logic     rstn,
	reg_port_if.regs regs
);

	logic [31:0] gpr [0:14];   // r0..r14
	logic [31:0] pc;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < 15; i++) begin
				gpr[i] <= 32'h0;
			end
			pc <= RESET_VECTOR;
		end else begin
			if (regs.wr_en && regs.wr_addr != 4'd15)   // r15 only via pc port
				gpr[regs.wr_addr] <= regs.wr_data;
			if (regs.pc_we)
				pc <= regs.pc_wdata;
		end
	end

	// pc+8 seen by the executing instruction
	assign regs.ra_data = (regs.ra_addr == 4'd15) ? pc + 32'd8 : gpr[regs.ra_addr];
	assign regs.rb_data = (regs.rb_addr == 4'd15) ? pc + 32'd8 : gpr[regs.rb_addr];
	assign regs.pc = pc;

endmodule

`default_nettype wire

//--- rtl/operand_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module operand_shifter (
	shift_if.shifter sh
);

	logic [4:0]  rot;
	logic [4:0]  amt;
	logic [63:0] imm_dbl;
	logic [31:0] imm_word;
	logic [63:0] rm_dbl;
	logic [32:0] left;
	logic [32:0] right;
	logic [32:0] arith;

	assign rot = {sh.op2[11:8], 1'b0};   // twice the rotate field
	assign amt = sh.op2[11:7];
	assign imm_dbl = {24'b0, sh.op2[7:0], 24'b0, sh.op2[7:0]} >> rot;
	assign imm_word = imm_dbl[31:0];
	assign rm_dbl = {sh.rm_val, sh.rm_val} >> amt;
	assign left = {1'b0, sh.rm_val} << amt;     // bit 32 is last bit shifted out
	assign right = {sh.rm_val, 1'b0} >> amt;    // bit 0 is last bit shifted out
	assign arith = $signed({sh.rm_val, 1'b0}) >>> amt;

	always_comb begin
		sh.operand = sh.rm_val;
		sh.carry = sh.carry_in;
		if (sh.imm) begin
			sh.operand = imm_word;
			sh.carry = (rot == 5'd0) ? sh.carry_in : imm_word[31];
		end else begin
			case (sh.op2[6:5])
				arm_pkg::SH_LSL: begin
					if (amt != 5'd0)
						{sh.carry, sh.operand} = left;
				end
				arm_pkg::SH_LSR: begin
					if (amt == 5'd0) begin   // #0 encodes #32
						sh.operand = 32'h0;
						sh.carry = sh.rm_val[31];
					end else
						{sh.operand, sh.carry} = right;
				end
				arm_pkg::SH_ASR: begin
					if (amt == 5'd0) begin
						sh.operand = {32{sh.rm_val[31]}};
						sh.carry = sh.rm_val[31];
					end else
						{sh.operand, sh.carry} = arith;
				end
				arm_pkg::SH_ROR: begin
					if (amt == 5'd0)   // rrx
						{sh.operand, sh.carry} = {sh.carry_in, sh.rm_val};
					else begin
						sh.operand = rm_dbl[31:0];
						sh.carry = rm_dbl[31];
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	alu_if.alu ex
);

	shift_if     sh_bus ();
	logic [31:0] op2_val;
	logic [31:0] add_a;
	logic [31:0] add_b;
	logic        add_ci;
	logic [32:0] sum;
	logic        ovf;
	logic        logical;
	logic [31:0] res;

	operand_shifter u_shift (.sh(sh_bus));

	assign sh_bus.op2 = ex.op2;
	assign sh_bus.imm = ex.imm;
	assign sh_bus.rm_val = ex.rm_val;
	assign sh_bus.carry_in = ex.carry_in;
	assign op2_val = sh_bus.operand;

	// every arithmetic op is a + b + ci with inverted inputs for subtraction
	always_comb begin
		add_a = ex.rn_val;
		add_b = op2_val;
		add_ci = 1'b0;
		case (ex.opcode)
			arm_pkg::OP_SUB, arm_pkg::OP_CMP: begin
				add_b = ~op2_val;
				add_ci = 1'b1;
			end
			arm_pkg::OP_RSB: begin
				add_a = op2_val;
				add_b = ~ex.rn_val;
				add_ci = 1'b1;
			end
			arm_pkg::OP_ADD, arm_pkg::OP_CMN: add_ci = 1'b0;
			arm_pkg::OP_ADC: add_ci = ex.carry_in;
			arm_pkg::OP_SBC: begin
				add_b = ~op2_val;
				add_ci = ex.carry_in;
			end
			arm_pkg::OP_RSC: begin
				add_a = op2_val;
				add_b = ~ex.rn_val;
				add_ci = ex.carry_in;
			end
			default: add_ci = 1'b0;
		endcase
	end

	assign sum = {1'b0, add_a} + {1'b0, add_b} + {32'b0, add_ci};
	assign ovf = (add_a[31] == add_b[31]) && (sum[31] != add_a[31]);

	always_comb begin
		logical = 1'b1;
		case (ex.opcode)
			arm_pkg::OP_AND, arm_pkg::OP_TST: res = ex.rn_val & op2_val;
			arm_pkg::OP_EOR, arm_pkg::OP_TEQ: res = ex.rn_val ^ op2_val;
			arm_pkg::OP_ORR: res = ex.rn_val | op2_val;
			arm_pkg::OP_MOV: res = op2_val;
			arm_pkg::OP_BIC: res = ex.rn_val & ~op2_val;
			arm_pkg::OP_MVN: res = ~op2_val;
			default: begin
				res = sum[31:0];
				logical = 1'b0;
			end
		endcase
	end

	assign ex.result = res;
	assign ex.n = res[31];
	assign ex.z = (res == 32'h0);
	assign ex.c = logical ? sh_bus.carry : sum[32];
	assign ex.v = logical ? ex.v_in : ovf;
	assign ex.writes_rd = (ex.opcode[3:2] != 2'b10);   // tst teq cmp cmn

endmodule

`default_nettype wire

//--- rtl/cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
	input  logic        clk,
	input  logic        rstn,
	reg_port_if.ctrl    regs,
	alu_if.ctrl         ex,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	output logic        mem_read,
	output logic        mem_write,
	input  logic [31:0] mem_rdata,
	input  logic        mem_ok
);

	logic [1:0]      state;
	logic [1:0]      next_state;
	arm_pkg::instr_u ir;
	logic            f_n, f_z, f_c, f_v;
	logic            flag_we;
	logic            cond_pass;
	logic            is_dp, is_ls, is_br;
	logic [31:0]     seq_pc;
	logic [31:0]     br_target;
	logic [31:0]     ls_offs_addr;
	logic [31:0]     ls_addr_q;   // transfer address latched in ID before writeback

	assign is_dp = (ir.dp.cls == arm_pkg::CLASS_DP);
	assign is_ls = (ir.ls.cls == arm_pkg::CLASS_LS);
	assign is_br = (ir.br.cls == arm_pkg::CLASS_BR) && ir.br.one;

	always_comb begin
		case (ir.dp.cond)
			arm_pkg::COND_EQ: cond_pass = f_z;
			arm_pkg::COND_NE: cond_pass = !f_z;
			arm_pkg::COND_CS: cond_pass = f_c;
			arm_pkg::COND_CC: cond_pass = !f_c;
			arm_pkg::COND_MI: cond_pass = f_n;
			arm_pkg::COND_PL: cond_pass = !f_n;
			arm_pkg::COND_VS: cond_pass = f_v;
			arm_pkg::COND_VC: cond_pass = !f_v;
			arm_pkg::COND_HI: cond_pass = f_c && !f_z;
			arm_pkg::COND_LS: cond_pass = !f_c || f_z;
			arm_pkg::COND_GE: cond_pass = (f_n == f_v);
			arm_pkg::COND_LT: cond_pass = (f_n != f_v);
			arm_pkg::COND_GT: cond_pass = !f_z && (f_n == f_v);
			arm_pkg::COND_LE: cond_pass = f_z || (f_n != f_v);
			arm_pkg::COND_AL: cond_pass = 1'b1;
			default: cond_pass = 1'b0;   // nv
		endcase
	end

	assign regs.ra_addr = ir.dp.rn;
	assign regs.rb_addr = is_ls ? ir.ls.rd : ir.dp.op2[3:0];   // store data or rm
	assign ex.opcode = ir.dp.opcode;
	assign ex.rn_val = regs.ra_data;
	assign ex.rm_val = regs.rb_data;
	assign ex.op2 = ir.dp.op2;
	assign ex.imm = ir.dp.imm;
	assign ex.carry_in = f_c;
	assign ex.v_in = f_v;

	assign seq_pc = regs.pc + 32'd4;
	assign br_target = regs.pc + 32'd8 + {{6{ir.br.offset[23]}}, ir.br.offset, 2'b00};
	assign ls_offs_addr = ir.ls.u ? regs.ra_data + {20'b0, ir.ls.offset}
		: regs.ra_data - {20'b0, ir.ls.offset};
	assign mem_wdata = regs.rb_data;

	always_comb begin
		next_state = state;
		regs.wr_en = 1'b0;
		regs.wr_addr = ir.ls.rd;
		regs.wr_data = ex.result;
		regs.pc_we = 1'b0;
		regs.pc_wdata = seq_pc;
		mem_addr = regs.pc;
		mem_read = 1'b0;
		mem_write = 1'b0;
		flag_we = 1'b0;
		case (state)
			arm_pkg::ST_INIT: next_state = arm_pkg::ST_IF;
			arm_pkg::ST_IF: begin
				mem_read = 1'b1;
				if (mem_ok)
					next_state = arm_pkg::ST_ID;
			end
			arm_pkg::ST_ID: begin
				next_state = arm_pkg::ST_EX;
				if (!cond_pass) begin   // skip to next instruction
					regs.pc_we = 1'b1;
					next_state = arm_pkg::ST_IF;
				end else if (is_ls && (!ir.ls.p || ir.ls.w)) begin
					regs.wr_en = 1'b1;
					regs.wr_addr = ir.ls.rn;
					regs.wr_data = ls_offs_addr;
				end
			end
			arm_pkg::ST_EX: begin
				next_state = arm_pkg::ST_IF;
				regs.pc_we = 1'b1;
				if (is_br) begin
					regs.pc_wdata = br_target;
					regs.wr_en = ir.br.link;   // return address to lr
					regs.wr_addr = 4'd14;
					regs.wr_data = seq_pc;
				end else if (is_ls) begin
					mem_addr = ls_addr_q;
					mem_read = ir.ls.l;
					mem_write = !ir.ls.l;
					regs.wr_en = ir.ls.l && mem_ok;
					regs.wr_data = mem_rdata;
					if (!mem_ok) begin   // hold everything until the ack
						regs.pc_we = 1'b0;
						next_state = arm_pkg::ST_EX;
					end
				end else if (is_dp) begin
					regs.wr_en = ex.writes_rd;
					flag_we = ir.dp.s;
				end
			end
			default: next_state = arm_pkg::ST_INIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= arm_pkg::ST_INIT;
			{f_n, f_z, f_c, f_v} <= 4'h0;
		end else begin
			state <= next_state;
			if (flag_we)
				{f_n, f_z, f_c, f_v} <= {ex.n, ex.z, ex.c, ex.v};
		end
	end

	always_ff @(posedge clk) begin
		if (state == arm_pkg::ST_IF && mem_ok)
			ir <= mem_rdata;
		if (state == arm_pkg::ST_ID)
			ls_addr_q <= ir.ls.p ? ls_offs_addr : regs.ra_data;   // post-index uses old base
	end

endmodule

`default_nettype wire

//--- rtl/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
	parameter logic [31:0] RESET_VECTOR = 32'h0800_0000
) (
	input  logic        clk,
	input  logic        rstn,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	input  logic [31:0] mem_rdata,
	output logic        mem_read,
	output logic        mem_write,
	input  logic        mem_ok
);

	reg_port_if rp ();
	alu_if      ab ();

	reg_file #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_regs (
		.clk  (clk),
		.rstn (rstn),
		.regs (rp)
	);

	alu u_alu (
		.ex (ab)
	);

	cpu_control u_ctrl (
		.clk       (clk),
		.rstn      (rstn),
		.regs      (rp),
		.ex        (ab),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_rdata (mem_rdata),
		.mem_ok    (mem_ok)
	);

endmodule

`default_nettype wire

//--- verif/cpu_core_props.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core_props (
	input wire        clk,
	input wire        rstn,
	input wire        mem_read,
	input wire        mem_write,
	input wire        mem_ok,
	input wire [31:0] mem_addr,
	input wire [31:0] mem_wdata
);

	a_one_dir: assert property (@(posedge clk) disable iff (!rstn) !(mem_read && mem_write))
		else $error("read and write requested together");

	a_idle_in_reset: assert property (@(posedge clk) !rstn |-> (!mem_read && !mem_write))
		else $error("memory request during reset");

	// request held steady until acknowledged
	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		(mem_read || mem_write) && !mem_ok |=>
		$stable(mem_addr) && $stable(mem_read) && $stable(mem_write))
		else $error("request changed before mem_ok");

	a_wdata: assert property (@(posedge clk) disable iff (!rstn)
		mem_write && !mem_ok |=> $stable(mem_wdata))
		else $error("write data changed before mem_ok");

endmodule

bind cpu_core cpu_core_props u_props (
	.clk       (clk),
	.rstn      (rstn),
	.mem_read  (mem_read),
	.mem_write (mem_write),
	.mem_ok    (mem_ok),
	.mem_addr  (mem_addr),
	.mem_wdata (mem_wdata)
);

`default_nettype wire

//--- verif/arm_model.svh
`ifndef ARM_MODEL_SVH
`define ARM_MODEL_SVH

logic [31:0] m_r [0:15];
logic [31:0] m_pc;
logic        m_n, m_z, m_c, m_v;
logic [31:0] m_mem [int unsigned];
logic [64:0] exp_q [$];   // {write, addr, data} per completed transfer

function automatic logic [31:0] fill_word(input logic [31:0] a);
	return {a[15:0], a[31:16]} ^ 32'hc3a5_96e1;
endfunction

function automatic logic [31:0] model_read(input logic [31:0] a);
	if (m_mem.exists(a))
		return m_mem[a];
	return fill_word(a);
endfunction

function automatic logic [31:0] reg_val(input logic [3:0] i);
	return (i == 4'd15) ? m_pc + 32'd8 : m_r[i];   // pc reads 8 ahead
endfunction

function automatic logic cond_holds(input logic [3:0] c);
	case (c)
		4'h0: return m_z;
		4'h1: return !m_z;
		4'h2: return m_c;
		4'h3: return !m_c;
		4'h4: return m_n;
		4'h5: return !m_n;
		4'h6: return m_v;
		4'h7: return !m_v;
		4'h8: return m_c && !m_z;
		4'h9: return !m_c || m_z;
		4'ha: return m_n == m_v;
		4'hb: return m_n != m_v;
		4'hc: return !m_z && (m_n == m_v);
		4'hd: return m_z || (m_n != m_v);
		4'he: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// {carry, value} of operand 2
function automatic logic [32:0] operand2(input logic imm, input logic [11:0] f,
		input logic [31:0] rm, input logic cin);
	int r;
	int a;
	logic [31:0] v;
	logic [31:0] b;
	if (imm) begin
		r = f[11:8] * 2;
		b = {24'b0, f[7:0]};
		v = (r == 0) ? b : (b >> r) | (b << (32 - r));
		return {(r == 0) ? cin : v[31], v};
	end
	a = f[11:7];
	case (f[6:5])
		2'b00: begin
			if (a == 0)
				return {cin, rm};
			return {rm[32 - a], rm << a};
		end
		2'b01: begin
			if (a == 0)
				return {rm[31], 32'h0};   // lsr #32
			return {rm[a - 1], rm >> a};
		end
		2'b10: begin
			if (a == 0)
				return {rm[31], {32{rm[31]}}};
			v = $signed(rm) >>> a;
			return {rm[a - 1], v};
		end
		default: begin
			if (a == 0)
				return {rm[0], cin, rm[31:1]};   // rrx
			return {rm[a - 1], (rm >> a) | (rm << (32 - a))};
		end
	endcase
endfunction

// {v, c, sum} as the architecture defines add with carry
function automatic logic [33:0] add_carry(input logic [31:0] a, input logic [31:0] b,
		input logic ci);
	logic [32:0] s;
	s = {1'b0, a} + {1'b0, b} + {32'b0, ci};
	return {(a[31] == b[31]) && (s[31] != a[31]), s};
endfunction

task automatic model_step(input logic [31:0] iw);
	logic [32:0] sh;
	logic [33:0] ad;
	logic [31:0] a;
	logic [31:0] res;
	logic [31:0] offs;
	logic [31:0] xfer;
	logic        logical;
	logic [3:0]  op;
	if (!cond_holds(iw[31:28])) begin
		m_pc = m_pc + 32'd4;
		return;
	end
	case (iw[27:26])
		2'b00: begin
			a = reg_val(iw[19:16]);
			op = iw[24:21];
			sh = operand2(iw[25], iw[11:0], reg_val(iw[3:0]), m_c);
			logical = 1'b0;
			case (op)
				arm_pkg::OP_SUB, arm_pkg::OP_CMP: ad = add_carry(a, ~sh[31:0], 1'b1);
				arm_pkg::OP_RSB: ad = add_carry(sh[31:0], ~a, 1'b1);
				arm_pkg::OP_ADD, arm_pkg::OP_CMN: ad = add_carry(a, sh[31:0], 1'b0);
				arm_pkg::OP_ADC: ad = add_carry(a, sh[31:0], m_c);
				arm_pkg::OP_SBC: ad = add_carry(a, ~sh[31:0], m_c);
				arm_pkg::OP_RSC: ad = add_carry(sh[31:0], ~a, m_c);
				default: begin
					ad = 34'h0;
					logical = 1'b1;
				end
			endcase
			case (op)
				arm_pkg::OP_AND, arm_pkg::OP_TST: res = a & sh[31:0];
				arm_pkg::OP_EOR, arm_pkg::OP_TEQ: res = a ^ sh[31:0];
				arm_pkg::OP_ORR: res = a | sh[31:0];
				arm_pkg::OP_MOV: res = sh[31:0];
				arm_pkg::OP_BIC: res = a & ~sh[31:0];
				arm_pkg::OP_MVN: res = ~sh[31:0];
				default: res = ad[31:0];
			endcase
			if (op[3:2] != 2'b10)   // compares leave rd alone
				m_r[iw[15:12]] = res;
			if (iw[20]) begin
				m_n = res[31];
				m_z = (res == 32'h0);
				m_c = logical ? sh[32] : ad[32];
				if (!logical)
					m_v = ad[33];
			end
		end
		2'b01: begin
			a = reg_val(iw[19:16]);
			offs = iw[23] ? a + {20'b0, iw[11:0]} : a - {20'b0, iw[11:0]};
			xfer = iw[24] ? offs : a;
			if (!iw[24] || iw[21])
				m_r[iw[19:16]] = offs;
			if (iw[20]) begin
				exp_q.push_back({1'b0, xfer, 32'h0});
				m_r[iw[15:12]] = model_read(xfer);
			end else begin
				exp_q.push_back({1'b1, xfer, reg_val(iw[15:12])});
				m_mem[xfer] = reg_val(iw[15:12]);
			end
		end
		default: begin
			if (iw[24])
				m_r[14] = m_pc + 32'd4;   // return address
			m_pc = m_pc + 32'd8 + {{6{iw[23]}}, iw[23:0], 2'b00};
			return;
		end
	endcase
	m_pc = m_pc + 32'd4;
endtask

`endif

//--- verif/tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

	localparam logic [31:0] RESET_VECTOR = 32'h0800_0000;
	localparam int          NUM_INSTR = 64;
	localparam int          TIMEOUT = 20000;
	localparam logic [31:0] SELF_ADDR = RESET_VECTOR + 4 * (NUM_INSTR - 1);

	logic        clk;
	logic        rstn;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [31:0] mem_rdata;
	logic        mem_read;
	logic        mem_write;
	logic        mem_ok;

	logic [31:0] lfsr;
	logic [31:0] mem [int unsigned];
	int          errors;
	int          xfers;
	int          exp_count;
	int          wait_left;
	int          cycles;
	logic        busy;
	logic        done;
	logic        seen_first;

	`include "arm_model.svh"

	cpu_core #(
		.RESET_VECTOR(RESET_VECTOR)
	) uut (
		.clk       (clk),
		.rstn      (rstn),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_ok    (mem_ok)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] tb_read(input logic [31:0] a);
		if (mem.exists(a))
			return mem[a];
		return fill_word(a);
	endfunction

	task automatic build_program();
		logic [31:0] w;
		logic [3:0]  cnd;
		logic [3:0]  op;
		logic [2:0]  rd;
		logic [2:0]  rn;
		logic [11:0] op2;
		logic [3:0]  ofs;
		logic [1:0]  kind;
		logic        imm;
		logic        s;
		logic        p;
		logic        u;
		logic        wb;
		int          k;
		for (int i = 0; i < NUM_INSTR; i++) begin
			if (i == 0)
				w = 32'he3a0_8080;   // mov r8, #0x80
			else if (i == 1)
				w = {4'he, 3'b000, 4'hd, 1'b0, 4'h0, 4'h8, 5'd22, 2'b00, 1'b0, 4'h8};
			else if (i == 2)
				w = 32'he288_8080;   // data region base 0x2000_0080
			else if (i == NUM_INSTR - 1)
				w = 32'heaff_fffe;   // branch to self
			else begin
				cnd = rand_bits(1) ? arm_pkg::COND_AL : rand_bits(4);
				if (cnd == 4'hf)
					cnd = arm_pkg::COND_AL;
				kind = rand_bits(2);
				if (kind == 2'd2) begin
					p = rand_bits(1);
					u = rand_bits(1);
					wb = p ? rand_bits(1) : 1'b0;
					s = rand_bits(1);   // load when set
					rd = rand_bits(3);
					ofs = rand_bits(4);
					op2 = {6'b0, ofs, 2'b00};
					w = {cnd, 3'b010, p, u, 1'b0, wb, s, 4'd8, 1'b0, rd, op2};
				end else if (kind == 2'd3) begin
					s = rand_bits(1);   // link
					k = rand_bits(2);
					if (i + 2 + k > NUM_INSTR - 1)
						k = NUM_INSTR - 3 - i;
					w = {cnd, 3'b101, s, k[23:0]};
				end else begin
					imm = rand_bits(1);
					op = rand_bits(4);
					s = rand_bits(1);
					rn = rand_bits(3);
					rd = rand_bits(3);
					if (imm)
						op2 = rand_bits(12);
					else begin
						op2[11:7] = rand_bits(5);
						op2[6:5] = rand_bits(2);
						op2[4:3] = 2'b00;
						op2[2:0] = rand_bits(3);
					end
					w = {cnd, 2'b00, imm, op, s, 1'b0, rn, 1'b0, rd, op2};
				end
			end
			mem[RESET_VECTOR + 4 * i] = w;
			m_mem[RESET_VECTOR + 4 * i] = w;
		end
	endtask

	task automatic run_model();
		int steps;
		steps = 0;
		m_pc = RESET_VECTOR;
		{m_n, m_z, m_c, m_v} = 4'h0;
		for (int i = 0; i < 16; i++) begin
			m_r[i] = 32'h0;
		end
		while (steps < 2000) begin
			exp_q.push_back({1'b0, m_pc, 32'h0});   // fetch
			if (m_pc == SELF_ADDR)
				break;
			model_step(model_read(m_pc));
			steps++;
		end
	endtask

	// memory responder with 0..3 wait cycles
	always @(negedge clk) begin
		if (mem_ok) begin
			mem_ok = 1'b0;
			busy = 1'b0;
		end
		if (rstn && (mem_read || mem_write) && !busy) begin
			busy = 1'b1;
			wait_left = rand_bits(2);
		end
		if (busy) begin
			if (wait_left == 0) begin
				mem_ok = 1'b1;
				mem_rdata = mem_read ? tb_read(mem_addr) : 32'h0;
			end else
				wait_left--;
		end
	end

	always @(posedge clk) begin : monitor
		logic [64:0] e;
		if (rstn && !done && mem_ok && (mem_read || mem_write)) begin
			xfers++;
			if (!seen_first) begin
				seen_first = 1'b1;
				assert (mem_read && mem_addr == RESET_VECTOR) else begin
					$display("[ERROR] first fetch mem_addr exp %h got %h", RESET_VECTOR, mem_addr);
					errors++;
				end
			end
			if (mem_write)
				mem[mem_addr] = mem_wdata;
			assert (exp_q.size() > 0) else begin
				$display("transfer completed after the model had no transfers left");
				errors++;
			end
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				assert (mem_write == e[64]) else begin
					$display("[ERROR] mem_write exp %h got %h", e[64], mem_write);
					errors++;
				end
				assert (mem_addr == e[63:32]) else begin
					$display("[ERROR] mem_addr exp %h got %h", e[63:32], mem_addr);
					errors++;
				end
				if (e[64] && mem_write) begin
					assert (mem_wdata == e[31:0]) else begin
						$display("[ERROR] mem_wdata exp %h got %h", e[31:0], mem_wdata);
						errors++;
					end
				end
			end
			if (mem_read && mem_addr == SELF_ADDR)
				done = 1'b1;
		end
	end

	initial begin
		rstn = 1'b0;
		mem_ok = 1'b0;
		mem_rdata = 32'h0;
		lfsr = 32'hb2a6_7f20;
		errors = 0;
		xfers = 0;
		wait_left = 0;
		busy = 1'b0;
		done = 1'b0;
		seen_first = 1'b0;
		build_program();
		run_model();
		exp_count = exp_q.size();
		repeat (3) @(negedge clk);
		rstn = 1'b1;
		cycles = 0;
		while (!done && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		assert (done) else begin
			$display("timeout: branch-to-self not reached within %0d cycles", TIMEOUT);
			errors++;
		end
		assert (xfers == exp_count) else begin
			$display("[ERROR] transfer count exp %h got %h", exp_count, xfers);
			errors++;
		end
		foreach (m_mem[a])
			assert (tb_read(a) == m_mem[a]) else begin
				$display("[ERROR] mem[%h] exp %h got %h", a, m_mem[a], tb_read(a));
				errors++;
			end
		foreach (mem[a])
			assert (model_read(a) == mem[a]) else begin
				$display("[ERROR] mem[%h] exp %h got %h", a, model_read(a), mem[a]);
				errors++;
			end
		$display("errors: %0d, transfers: %0d of %0d", errors, xfers, exp_count);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+verif
rtl/arm_pkg.sv
rtl/core_ifs.sv
rtl/reg_file.sv
rtl/operand_shifter.sv
rtl/alu.sv
rtl/cpu_control.sv
rtl/cpu_core.sv
verif/cpu_core_props.sv
verif/tb_cpu_core.sv
